//--- project.f
common/alu_pkg.sv
source/chunk_counter.sv
source/alu_ctrl_fsm.sv
chunk_alu/ripple_arith.sv
chunk_alu/reduce_unit.sv
source/chunked_alu_top.sv
dv/tb_clock_gen.sv
dv/chunked_alu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the chunked ALU testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module chunked_alu_tb \
    -f project.f \
    -o sim_chunked_alu

./obj_dir/sim_chunked_alu | tee sim.log

# the testbench prints its verdict on a line of its own
if grep -qx "RESULT: PASS" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

//--- dv/alu_patterns.txt
// op a b result flag, all hex
// op codes: 0 add, 1 sub, 2 eq, 3 neq, 4 and, 5 or, 6 xor
0 00000000 00000000 00000000 0
0 000000ff 00000001 00000100 0
0 00ffffff 00000001 01000000 0
0 ffffffff 00000001 00000000 1
0 12345678 87654321 99999999 0
0 80000000 80000000 00000000 1
0 ffff00ff 0000ff01 00000000 1
0 deadbeef 01010101 dfaebff0 0
1 00000005 00000003 00000002 0
1 00000100 00000001 000000ff 0
1 00000000 00000001 ffffffff 1
1 01000000 00000001 00ffffff 0
1 12345678 12345678 00000000 0
1 00000001 80000000 80000001 1
1 ffffffff fffffffe 00000001 0
2 12345678 12345678 00000000 1
2 12345678 12345679 00000000 0
2 00000000 80000000 00000000 0
3 aaaaaaaa aaaaaaaa 00000000 0
3 aaaaaaaa aaabaaaa 00000000 1
4 ffffffff 00000000 00000000 1
4 fffffffe 00000000 00000000 0
4 7fffffff 12345678 00000000 0
5 00000000 ffffffff 00000000 0
5 00000100 00000000 00000000 1
5 80000000 00000000 00000000 1
6 00000001 00000000 00000000 1
6 00000003 00000000 00000000 0
6 01010101 00000000 00000000 0
6 01010100 00000000 00000000 1
6 12345678 00000000 00000000 1

//--- dv/chunked_alu_tb.sv
`default_nettype none
`timescale 1ns/1ps

module chunked_alu_tb
    import alu_pkg::*;
;

    logic                  clk;
    logic                  rst;
    logic                  req;
    alu_op_t               op;
    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
    logic                  ack;
    logic [data_width-1:0] result;
    logic                  flag;

    // bookkeeping
    int   seed;
    int   checks;
    int   errors;
    int   timeouts;
    int   timeout_cycles;
    logic timed_out;

    tb_clock_gen u_clk (
        .clk (clk)
    );

    chunked_alu_top uut (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .op     (op),
        .a      (a),
        .b      (b),
        .ack    (ack),
        .result (result),
        .flag   (flag)
    );

    //////////////////////////////////////////////////
    // expected values from the ALU rules
    //////////////////////////////////////////////////

    // returns {flag, result}
    function automatic logic [data_width:0] compute_expected(
        input alu_op_t               op_in,
        input logic [data_width-1:0] a_in,
        input logic [data_width-1:0] b_in
    );
        logic [data_width:0]   wide;
        logic [data_width-1:0] res;
        logic                  fl;
        wide = '0;
        res  = '0;
        fl   = 1'b0;
        case (op_in)
            op_add: begin
                wide = {1'b0, a_in} + {1'b0, b_in};
                res  = wide[data_width-1:0];
                fl   = wide[data_width];
            end
            op_sub: begin
                res = a_in - b_in;
                // borrow whenever b is the larger unsigned value
                fl  = (a_in < b_in);
            end
            op_eq:   fl = (a_in == b_in);
            op_neq:  fl = (a_in != b_in);
            op_and:  fl = &a_in;
            op_or:   fl = |a_in;
            op_xor:  fl = ^a_in;
            default: fl = 1'b0;
        endcase
        return {fl, res};
    endfunction

    //////////////////////////////////////////////////
    // compare helpers
    //////////////////////////////////////////////////

    task automatic check_word(input string name, input logic [data_width-1:0] expected,
                              input logic [data_width-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t: %s expected %b got %b", $time, name, expected, actual);
        end
    endtask

    // waits on falling edges until ack reaches level and counts the edges
    task automatic wait_ack(input logic level, output int cycles);
        cycles = 0;
        while (ack !== level && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (ack !== level) begin
            timeouts++;
            timed_out = 1'b1;
            $display("timeout at %0t: ack never went to %b within %0d cycles",
                     $time, level, timeout_cycles);
        end
    endtask

    //////////////////////////////////////////////////
    // one four-phase transfer
    //////////////////////////////////////////////////

    // entered and left on a falling edge
    task automatic run_op(input alu_op_t op_in, input logic [data_width-1:0] a_in,
                          input logic [data_width-1:0] b_in,
                          input logic [data_width-1:0] exp_res, input logic exp_flag,
                          input int hold);
        int lat;
        int n;
        // previous transfer must be fully closed
        wait_ack(1'b0, lat);
        if (!timed_out) begin
            op  = op_in;
            a   = a_in;
            b   = b_in;
            req = 1'b1;
            wait_ack(1'b1, lat);
        end
        if (!timed_out) begin
            // first negedge follows the capture edge, so edges after capture is lat - 1
            if (lat - 1 != chunk_count) begin
                errors++;
                $display("Error at %0t: ack latency expected %0d got %0d",
                         $time, chunk_count, lat - 1);
            end
            checks++;
            check_word("result", exp_res, result);
            check_bit("flag", exp_flag, flag);
            // back-pressure while the host keeps req up
            for (n = 0; n < hold; n++) begin
                @(negedge clk);
                check_bit("ack", 1'b1, ack);
                check_word("result", exp_res, result);
                check_bit("flag", exp_flag, flag);
            end
            req = 1'b0;
            // operands are free once req drops
            a = $random(seed);
            b = $random(seed);
            @(negedge clk);
            // ack must drop at the very first edge with req low
            check_bit("ack", 1'b0, ack);
            check_word("result", exp_res, result);
            check_bit("flag", exp_flag, flag);
        end
    endtask

    //////////////////////////////////////////////////
    // test phases
    //////////////////////////////////////////////////

    task automatic check_reset();
        int n;
        for (n = 0; n < 8; n++) begin
            @(negedge clk);
            check_bit("ack", 1'b0, ack);
            check_word("result", '0, result);
            check_bit("flag", 1'b0, flag);
        end
        rst = 1'b0;
        // first cycle out of reset
        @(negedge clk);
        check_bit("ack", 1'b0, ack);
        check_word("result", '0, result);
        check_bit("flag", 1'b0, flag);
    endtask

    task automatic run_pattern_file();
        int                    fd;
        int                    code;
        int                    fields;
        int                    n_ops;
        int                    hold;
        string                 line;
        logic [31:0]           f_op;
        logic [data_width-1:0] f_a;
        logic [data_width-1:0] f_b;
        logic [data_width-1:0] f_res;
        logic [31:0]           f_flag;
        n_ops = 0;
        fd = $fopen("dv/alu_patterns.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the pattern file dv/alu_patterns.txt");
        end else begin
            while (!$feof(fd) && !timed_out) begin
                code   = $fgets(line, fd);
                fields = 0;
                // comment and blank lines scan to fewer than five fields
                if (code > 0) begin
                    fields = $sscanf(line, "%h %h %h %h %h", f_op, f_a, f_b, f_res, f_flag);
                end
                if (fields == 5) begin
                    hold = 1 + ($unsigned($random(seed)) % 32'd10);
                    run_op(alu_op_t'(f_op[2:0]), f_a, f_b, f_res, f_flag[0], hold);
                    n_ops++;
                end
            end
            $fclose(fd);
            if (n_ops == 0) begin
                errors++;
                $display("the pattern file held no operations");
            end
        end
    endtask

    task automatic run_random_ops();
        int                    n;
        logic [31:0]           r;
        alu_op_t               rop;
        logic [data_width-1:0] ra;
        logic [data_width-1:0] rb;
        logic [data_width:0]   want;
        for (n = 0; n < 200 && !timed_out; n++) begin
            r   = $random(seed);
            rop = alu_op_t'(3'(r % 32'd7));
            ra  = $random(seed);
            rb  = $random(seed);
            // steer some operands so every flag value shows up
            if ((rop == op_eq || rop == op_neq) && r[9]) begin
                rb = ra;
            end
            if (rop == op_and && r[10]) begin
                ra = '1;
            end
            if (rop == op_or && r[11]) begin
                ra = '0;
            end
            want = compute_expected(rop, ra, rb);
            // back to back with req dropped as soon as ack is seen
            run_op(rop, ra, rb, want[data_width-1:0], want[data_width], 0);
        end
    endtask

    task automatic report_results();
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        seed           = 79208;
        checks         = 0;
        errors         = 0;
        timeouts       = 0;
        timeout_cycles = 20;
        timed_out      = 1'b0;
        rst            = 1'b1;
        req            = 1'b0;
        op             = op_add;
        a              = '0;
        b              = '0;
        check_reset();
        if (!timed_out) begin
            run_pattern_file();
        end
        if (!timed_out) begin
            run_random_ops();
        end
        report_results();
    end

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    // 40 ns period, starts low so the first rising edge is at 20 ns
    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

endmodule

`default_nettype wire

//--- source/chunked_alu_top.sv
`default_nettype none
`timescale 1ns/1ps

module chunked_alu_top
    import alu_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   req,
    input  alu_op_t               op,
    input  wire  [data_width-1:0] a,
    input  wire  [data_width-1:0] b,
    output logic                  ack,
    output logic [data_width-1:0] result,
    output logic                  flag
);

    // control
    logic                 load;
    logic                 step;
    alu_op_t              cur_op;
    logic [cnt_width-1:0] chunk_idx;
    logic                 last_chunk;

    // chunk datapath
    logic [chunk_width-1:0] a_chunk;
    logic [chunk_width-1:0] b_chunk;
    logic                   carry_out;

    //////////////////////////////////////////////////
    // sequencing
    //////////////////////////////////////////////////

    alu_ctrl_fsm u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .op         (op),
        .last_chunk (last_chunk),
        .ack        (ack),
        .load       (load),
        .step       (step),
        .cur_op     (cur_op)
    );

    chunk_counter u_cnt (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .step       (step),
        .chunk_idx  (chunk_idx),
        .last_chunk (last_chunk)
    );

    //////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////

    ripple_arith u_arith (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .step      (step),
        .cur_op    (cur_op),
        .a         (a),
        .b         (b),
        .a_chunk   (a_chunk),
        .b_chunk   (b_chunk),
        .carry_out (carry_out),
        .result    (result)
    );

    // flags follow the same chunk stream as the adder
    reduce_unit u_reduce (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .step      (step),
        .cur_op    (cur_op),
        .a_chunk   (a_chunk),
        .b_chunk   (b_chunk),
        .carry_out (carry_out),
        .flag      (flag)
    );

endmodule

`default_nettype wire

//--- chunk_alu/reduce_unit.sv
`default_nettype none
`timescale 1ns/1ps

module reduce_unit
    import alu_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   load,
    input  wire                   step,
    input  alu_op_t               cur_op,
    input  wire [chunk_width-1:0] a_chunk,
    input  wire [chunk_width-1:0] b_chunk,
    input  wire                   carry_out,
    output logic                  flag
);

    // running results over the chunks seen so far
    logic and_acc;
    logic or_acc;
    logic xor_acc;
    logic eq_acc;

    //////////////////////////////////////////////////
    // accumulators
    //////////////////////////////////////////////////

    // all four run in parallel whatever the opcode,
    // the flag mux picks the one that matters
    always_ff @(posedge clk) begin
        if (rst) begin
            and_acc <= 1'b0;
            or_acc  <= 1'b0;
            xor_acc <= 1'b0;
            eq_acc  <= 1'b0;
        end else if (load) begin
            // identity values for each fold
            and_acc <= 1'b1;
            or_acc  <= 1'b0;
            xor_acc <= 1'b0;
            eq_acc  <= 1'b1;
        end else if (step) begin
            and_acc <= and_acc & (&a_chunk);
            or_acc  <= or_acc | (|a_chunk);
            xor_acc <= xor_acc ^ (^a_chunk);
            // one mismatching chunk clears it for good
            eq_acc  <= eq_acc & (a_chunk == b_chunk);
        end
    end

    //////////////////////////////////////////////////
    // flag select
    //////////////////////////////////////////////////

    always_comb begin
        case (cur_op)
            op_add, op_sub: begin
                // carry or borrow out of the top bit
                flag = carry_out;
            end
            op_eq: begin
                flag = eq_acc;
            end
            op_neq: begin
                flag = ~eq_acc;
            end
            op_and: begin
                flag = and_acc;
            end
            op_or: begin
                flag = or_acc;
            end
            op_xor: begin
                flag = xor_acc;
            end
            default: begin
                flag = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- chunk_alu/ripple_arith.sv
`default_nettype none
`timescale 1ns/1ps

module ripple_arith
    import alu_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    load,
    input  wire                    step,
    input  alu_op_t                cur_op,
    input  wire [data_width-1:0]   a,
    input  wire [data_width-1:0]   b,
    output logic [chunk_width-1:0] a_chunk,
    output logic [chunk_width-1:0] b_chunk,
    output logic                   carry_out,
    output logic [data_width-1:0]  result
);

    // operand shift registers, low chunk sits at the bottom
    logic [data_width-1:0] a_sh;
    logic [data_width-1:0] b_sh;

    // one extra bit holds the carry or borrow of this chunk
    logic [chunk_width:0]   sum_ext;
    logic [chunk_width:0]   diff_ext;
    logic [chunk_width-1:0] res_chunk;
    logic                   carry_next;

    assign a_chunk = a_sh[chunk_width-1:0];
    assign b_chunk = b_sh[chunk_width-1:0];

    //////////////////////////////////////////////////
    // chunk adder / subtractor
    //////////////////////////////////////////////////

    assign sum_ext  = {1'b0, a_chunk} + {1'b0, b_chunk} + {{chunk_width{1'b0}}, carry_out};
    // a negative difference wraps, so the top bit reads as the borrow
    assign diff_ext = {1'b0, a_chunk} - {1'b0, b_chunk} - {{chunk_width{1'b0}}, carry_out};

    always_comb begin
        case (cur_op)
            op_add: begin
                {carry_next, res_chunk} = sum_ext;
            end
            op_sub: begin
                {carry_next, res_chunk} = diff_ext;
            end
            default: begin
                // compares and reductions leave the result at zero
                carry_next = 1'b0;
                res_chunk  = '0;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // carry flop and result register
    //////////////////////////////////////////////////

    // result fills from the top, chunk 0 lands at the bottom after the last step
    always_ff @(posedge clk) begin
        if (rst) begin
            carry_out <= 1'b0;
            result    <= '0;
        end else if (load) begin
            carry_out <= 1'b0;
            result    <= '0;
        end else if (step) begin
            carry_out <= carry_next;
            result    <= {res_chunk, result[data_width-1:chunk_width]};
        end
    end

    // operand shifters
    always_ff @(posedge clk) begin
        if (load) begin
            a_sh <= a;
            b_sh <= b;
        end else if (step) begin
            a_sh <= a_sh >> chunk_width;
            b_sh <= b_sh >> chunk_width;
        end
    end

endmodule

`default_nettype wire

//--- source/alu_ctrl_fsm.sv
`default_nettype none
`timescale 1ns/1ps

module alu_ctrl_fsm
    import alu_pkg::*;
(
    input  wire     clk,
    input  wire     rst,
    input  wire     req,
    input  alu_op_t op,
    input  wire     last_chunk,
    output logic    ack,
    output logic    load,
    output logic    step,
    output alu_op_t cur_op
);

    ctrl_state_t state;
    ctrl_state_t state_next;

    //////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                // new request, operands get captured this edge
                if (req) begin
                    state_next = st_run;
                end
            end
            st_run: begin
                // leave once the top chunk is stepped
                if (last_chunk) begin
                    state_next = st_done;
                end
            end
            st_done: begin
                // hold ack until the host drops req
                if (!req) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // state, ack and opcode registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= st_idle;
            ack    <= 1'b0;
            cur_op <= op_add;
        end else begin
            state <= state_next;
            // ack tracks st_done, registered so it lines up with the state
            ack   <= (state_next == st_done);
            if (load) begin
                cur_op <= op;
            end
        end
    end

    // one capture cycle, then one step per chunk
    assign load = (state == st_idle) && req;
    assign step = (state == st_run);

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    // ack only comes up after the top chunk was processed
    a_ack_after_last: assert property (
        @(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(state == st_run && last_chunk)
    ) else $error("alu_ctrl_fsm: ack rose without finishing the run");

    // capture and processing never overlap
    a_load_step_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(load && step)
    ) else $error("alu_ctrl_fsm: load and step high together");

endmodule

`default_nettype wire

//--- source/chunk_counter.sv
`default_nettype none
`timescale 1ns/1ps

module chunk_counter
    import alu_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  load,
    input  wire                  step,
    output logic [cnt_width-1:0] chunk_idx,
    output logic                 last_chunk
);

    //////////////////////////////////////////////////
    // chunk index
    //////////////////////////////////////////////////

    // load restarts at chunk 0, each step moves one chunk up
    // the index wraps back to 0 after the top chunk
    always_ff @(posedge clk) begin
        if (rst) begin
            chunk_idx <= '0;
        end else if (load) begin
            chunk_idx <= '0;
        end else if (step) begin
            chunk_idx <= chunk_idx + 1'b1;
        end
    end

    // top chunk is being worked on this cycle
    assign last_chunk = (chunk_idx == cnt_width'(chunk_count - 1));

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    // the run has to stop right after the top chunk,
    // otherwise the index would wrap into a fifth step
    a_no_step_past_last: assert property (
        @(posedge clk) disable iff (rst)
        (step && last_chunk) |=> !step
    ) else $error("chunk_counter: step seen after last chunk");

endmodule

`default_nettype wire

//--- common/alu_pkg.sv
`default_nettype none

package alu_pkg;

    //////////////////////////////////////////////////
    // datapath sizing
    //////////////////////////////////////////////////

    // full operand and result width
    localparam int data_width = 32;

    // bits handled on each clock
    localparam int chunk_width = 8;

    // clocks per operation
    localparam int chunk_count = data_width / chunk_width;

    // enough bits to index every chunk
    localparam int cnt_width = $clog2(chunk_count);

    //////////////////////////////////////////////////
    // opcodes and control states
    //////////////////////////////////////////////////

    // arithmetic first, then compares, then reductions of a
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_eq  = 3'd2,
        op_neq = 3'd3,
        op_and = 3'd4,
        op_or  = 3'd5,
        op_xor = 3'd6
    } alu_op_t;

    // handshake sequencer states
    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_done
    } ctrl_state_t;

endpackage

`default_nettype wire
